// ==== source/alu_pkg.sv ====
// ALU flag path package with opcodes, request and flag structs, EFLAGS bit positions
`default_nettype none

package alu_pkg;

	//----------------------------------------------------------------------
	// Opcodes
	//----------------------------------------------------------------------
	// Arithmetic and logic first, flag-control operations last
	typedef enum logic [4:0] {
		ADD = 5'd0,
		ADC = 5'd1,
		SUB = 5'd2,
		SBB = 5'd3,
		CMP = 5'd4,
		AND = 5'd5,
		OR  = 5'd6,
		XOR = 5'd7,
		INC = 5'd8,
		DEC = 5'd9,
		DAA = 5'd10,
		STC = 5'd11,
		CLC = 5'd12,
		CMC = 5'd13,
		STD = 5'd14,
		CLD = 5'd15
	} alu_op_e;

	//----------------------------------------------------------------------
	// Request and status flags
	//----------------------------------------------------------------------
	// One operation as sampled on the strobe
	typedef struct packed {
		alu_op_e     op;
		logic [31:0] a;
		logic [31:0] b;
	} alu_req_t;

	// Status flags in EFLAGS position order from high to low
	typedef struct packed {
		logic of;
		logic df;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} status_flags_t;

	// Architectural bit positions in EFLAGS
	localparam int EFLAGS_CF = 0;
	localparam int EFLAGS_PF = 2;
	localparam int EFLAGS_AF = 4;
	localparam int EFLAGS_ZF = 6;
	localparam int EFLAGS_SF = 7;
	localparam int EFLAGS_DF = 10;
	localparam int EFLAGS_OF = 11;

endpackage

`default_nettype wire

// ==== source/alu_core.sv ====
// ALU core forming result, carry or borrow out and auxiliary carry for each opcode
`default_nettype none

module alu_core #(
	parameter int DATA_W = 32
) (
	input  alu_pkg::alu_req_t      req,
	input  alu_pkg::status_flags_t cur_flags,
	output logic [DATA_W-1:0]      sum,
	output logic                   carry_out,
	output logic                   aux_carry
);
	import alu_pkg::*;

	// Operands trimmed to the datapath width
	logic [DATA_W-1:0] opnd_a;
	logic [DATA_W-1:0] opnd_b;
	// Extra top bit holds carry or borrow
	logic [DATA_W:0]   ext;
	logic              carry_in;
	logic              is_sub;
	// DAA adjustment terms
	logic              lo_adj;
	logic              hi_adj;
	logic [7:0]        daa_byte;

	assign opnd_a = req.a[DATA_W-1:0];

	// INC and DEC behave as add or subtract of one
	assign opnd_b = (req.op == INC || req.op == DEC) ? DATA_W'(1) : req.b[DATA_W-1:0];

	// Only ADC and SBB consume the previous carry
	assign carry_in = (req.op == ADC || req.op == SBB) ? cur_flags.cf : 1'b0;
	assign is_sub   = (req.op == SUB || req.op == SBB || req.op == CMP || req.op == DEC);

	//----------------------------------------------------------------------
	// Decimal adjust of the low byte
	//----------------------------------------------------------------------
	// Low nibble past 9 or a pending half carry
	assign lo_adj   = (opnd_a[3:0] > 4'd9) || cur_flags.af;
	// Byte past 0x99 or a pending carry
	assign hi_adj   = (opnd_a[7:0] > 8'h99) || cur_flags.cf;
	assign daa_byte = opnd_a[7:0] + (lo_adj ? 8'h06 : 8'h00) + (hi_adj ? 8'h60 : 8'h00);

	//----------------------------------------------------------------------
	// Result select
	//----------------------------------------------------------------------
	always_comb begin
		ext       = '0;
		sum       = opnd_a;
		carry_out = 1'b0;
		aux_carry = 1'b0;
		case (req.op)
			ADD, ADC, INC, SUB, SBB, CMP, DEC: begin
				if (is_sub)
					ext = {1'b0, opnd_a} - {1'b0, opnd_b} - {{DATA_W{1'b0}}, carry_in};
				else
					ext = {1'b0, opnd_a} + {1'b0, opnd_b} + {{DATA_W{1'b0}}, carry_in};
				sum       = ext[DATA_W-1:0];
				carry_out = ext[DATA_W];
				// Carry or borrow into bit 4
				aux_carry = opnd_a[4] ^ opnd_b[4] ^ ext[4];
			end
			AND: sum = opnd_a & opnd_b;
			OR:  sum = opnd_a | opnd_b;
			XOR: sum = opnd_a ^ opnd_b;
			DAA: begin
				// Upper bits pass through untouched
				sum       = {opnd_a[DATA_W-1:8], daa_byte};
				carry_out = hi_adj;
				aux_carry = lo_adj;
			end
			// Flag-control operations produce no result
			default: sum = opnd_a;
		endcase
	end

	// Opcode must be a defined encoding whenever it reaches the core
	always_comb begin
		assert (!$isunknown(req.op) && req.op <= CLD)
			else $error("alu_core: undefined opcode %0h", req.op);
	end

endmodule

`default_nettype wire

// ==== source/flag_logic.sv ====
// Flag logic deriving next OF, DF, SF, ZF, AF, PF, CF and the per-opcode update mask
`default_nettype none

module flag_logic #(
	parameter int DATA_W = 32
) (
	input  alu_pkg::alu_op_e       op,
	input  logic [DATA_W-1:0]      a,
	input  logic [DATA_W-1:0]      b,
	input  logic [DATA_W-1:0]      sum,
	input  logic                   carry_out,
	input  logic                   aux_carry,
	input  alu_pkg::status_flags_t cur_flags,
	output alu_pkg::status_flags_t next_flags,
	output alu_pkg::status_flags_t update_mask
);
	import alu_pkg::*;

	logic [DATA_W-1:0] opnd_b;
	logic              add_of;
	logic              sub_of;
	logic              zero_full;
	logic              zero_byte;

	// Same operand seen by the core for INC and DEC
	assign opnd_b = (op == INC || op == DEC) ? DATA_W'(1) : b;

	//----------------------------------------------------------------------
	// Flag terms
	//----------------------------------------------------------------------
	// Add overflow when equal signs in give a different sign out
	assign add_of = (a[DATA_W-1] == opnd_b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
	// Subtract overflow when unequal signs in flip the sign of a
	assign sub_of = (a[DATA_W-1] != opnd_b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);

	assign zero_full = (sum == '0);
	// DAA judges zero on AL only
	assign zero_byte = (sum[7:0] == 8'h00);

	always_comb begin
		next_flags    = cur_flags;
		update_mask   = '0;
		// Common result flags
		next_flags.sf = sum[DATA_W-1];
		next_flags.zf = (op == DAA) ? zero_byte : zero_full;
		next_flags.pf = ~^sum[7:0];
		next_flags.af = aux_carry;
		next_flags.cf = carry_out;
		next_flags.of = 1'b0;
		case (op)
			ADD, ADC, INC: begin
				next_flags.of = add_of;
				update_mask   = '1;
				update_mask.df = 1'b0;
				// INC keeps CF
				update_mask.cf = (op != INC);
			end
			SUB, SBB, CMP, DEC: begin
				next_flags.of = sub_of;
				update_mask   = '1;
				update_mask.df = 1'b0;
				update_mask.cf = (op != DEC);
			end
			AND, OR, XOR: begin
				// Logic ops clear CF, OF and AF
				next_flags.cf = 1'b0;
				next_flags.af = 1'b0;
				update_mask    = '1;
				update_mask.df = 1'b0;
			end
			DAA: begin
				update_mask    = '1;
				update_mask.df = 1'b0;
				update_mask.of = 1'b0;
			end
			STC, CLC, CMC: begin
				next_flags.cf  = (op == STC) ? 1'b1 : (op == CMC) ? ~cur_flags.cf : 1'b0;
				update_mask.cf = 1'b1;
			end
			STD, CLD: begin
				next_flags.df  = (op == STD);
				update_mask.df = 1'b1;
			end
			default: update_mask = '0;
		endcase
	end

	// Direction flag reachable only through STD and CLD
	always_comb begin
		assert (!update_mask.df || op == STD || op == CLD)
			else $error("flag_logic: DF in mask for opcode %0h", op);
	end

endmodule

`default_nettype wire

// ==== source/eflags_reg.sv ====
// EFLAGS register with masked flag update and 32-bit architectural packing
`default_nettype none

module eflags_reg (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   op_valid,
	input  alu_pkg::status_flags_t next_flags,
	input  alu_pkg::status_flags_t update_mask,
	output alu_pkg::status_flags_t cur_flags,
	output logic [31:0]            eflags
);
	import alu_pkg::*;

	// Positions that carry a flag
	localparam logic [31:0] FLAG_POS_MASK = (32'd1 << EFLAGS_CF) | (32'd1 << EFLAGS_PF) |
		(32'd1 << EFLAGS_AF) | (32'd1 << EFLAGS_ZF) | (32'd1 << EFLAGS_SF) |
		(32'd1 << EFLAGS_DF) | (32'd1 << EFLAGS_OF);

	status_flags_t flags_q;

	//----------------------------------------------------------------------
	// Flag state
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			flags_q <= '0;
		end else if (op_valid) begin
			// Keep unmasked bits, take masked bits from the new value
			flags_q <= (flags_q & ~update_mask) | (next_flags & update_mask);
		end
	end

	assign cur_flags = flags_q;

	// Architectural packing
	always_comb begin
		eflags            = '0;
		eflags[EFLAGS_CF] = flags_q.cf;
		eflags[EFLAGS_PF] = flags_q.pf;
		eflags[EFLAGS_AF] = flags_q.af;
		eflags[EFLAGS_ZF] = flags_q.zf;
		eflags[EFLAGS_SF] = flags_q.sf;
		eflags[EFLAGS_DF] = flags_q.df;
		eflags[EFLAGS_OF] = flags_q.of;
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------
	// Reserved and system bits stay clear
	a_reserved_zero: assert property (@(posedge clk) (eflags & ~FLAG_POS_MASK) == 32'd0);

endmodule

`default_nettype wire

// ==== source/alu_flags_top.sv ====
// Top of the integer flag path joining core, flag logic and EFLAGS register
`default_nettype none

module alu_flags_top #(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              op_valid,
	input  alu_pkg::alu_req_t req,
	output logic              result_valid,
	output logic [DATA_W-1:0] result,
	output logic              result_we,
	output logic [31:0]       eflags
);
	import alu_pkg::*;

	logic [DATA_W-1:0] sum;
	logic              carry_out;
	logic              aux_carry;
	status_flags_t     cur_flags;
	status_flags_t     next_flags;
	status_flags_t     update_mask;
	// CMP and flag-control ops leave the destination alone
	logic              writes_result;

	alu_core #(
		.DATA_W (DATA_W)
	) core_i (
		.req       (req),
		.cur_flags (cur_flags),
		.sum       (sum),
		.carry_out (carry_out),
		.aux_carry (aux_carry)
	);

	flag_logic #(
		.DATA_W (DATA_W)
	) flags_i (
		.op          (req.op),
		.a           (req.a[DATA_W-1:0]),
		.b           (req.b[DATA_W-1:0]),
		.sum         (sum),
		.carry_out   (carry_out),
		.aux_carry   (aux_carry),
		.cur_flags   (cur_flags),
		.next_flags  (next_flags),
		.update_mask (update_mask)
	);

	// Flags land on the same edge as the result
	eflags_reg eflags_i (
		.clk         (clk),
		.rst         (rst),
		.op_valid    (op_valid),
		.next_flags  (next_flags),
		.update_mask (update_mask),
		.cur_flags   (cur_flags),
		.eflags      (eflags)
	);

	assign writes_result = !(req.op inside {CMP, STC, CLC, CMC, STD, CLD});

	//----------------------------------------------------------------------
	// Result stage, one cycle
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			result       <= '0;
			result_we    <= 1'b0;
		end else begin
			result_valid <= op_valid;
			// Held until the next strobe
			if (op_valid) begin
				result    <= sum;
				result_we <= writes_result;
			end
		end
	end

	// DF moves only on an edge that took an STD or CLD strobe
	a_df_hold: assert property (@(posedge clk) disable iff (rst)
		!(op_valid && (req.op inside {STD, CLD})) |=> cur_flags.df == $past(cur_flags.df));

endmodule

`default_nettype wire

// ==== test/alu_tb.sv ====
// Directed testbench for the integer flag path with a flag reference model
`default_nettype none

module alu_tb;
	import alu_pkg::*;

	localparam int DATA_W = 32;
	// Rough cycles per test summed for the watchdog
	localparam int TEST_CYCLES = 16 + 170 + 24 + 24 + 20 + 20;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	typedef struct packed {
		logic [DATA_W-1:0] res;
		logic              we;
		status_flags_t     flags;
	} expect_t;

	logic clk, rst, op_valid, result_valid, result_we;
	alu_req_t req;
	logic [DATA_W-1:0] result, last_res;
	logic [31:0] eflags, lcg_state;
	status_flags_t model_flags;
	expect_t exp_q[$];
	expect_t got_item;
	int cycle_cnt;

	alu_flags_top #(.DATA_W(DATA_W)) dut_i (
		.clk(clk),
		.rst(rst),
		.op_valid(op_valid),
		.req(req),
		.result_valid(result_valid),
		.result(result),
		.result_we(result_we),
		.eflags(eflags)
	);

	always #4 clk = ~clk;

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_result(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp));
	endtask

	task automatic check_flags(input status_flags_t got, input status_flags_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t eflags(of df sf zf af pf cf) got=%b exp=%b",
				$time, got, exp));
	endtask

	// Whole EFLAGS word including the reserved bits
	task automatic check_eflags(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t eflags got=%h exp=%h", $time, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t %s got=%b exp=%b", $time, name, got, exp));
	endtask

	function automatic status_flags_t unpack_flags(input logic [31:0] e);
		status_flags_t f;
		f.cf = e[EFLAGS_CF];
		f.pf = e[EFLAGS_PF];
		f.af = e[EFLAGS_AF];
		f.zf = e[EFLAGS_ZF];
		f.sf = e[EFLAGS_SF];
		f.df = e[EFLAGS_DF];
		f.of = e[EFLAGS_OF];
		return f;
	endfunction

	// Expected EFLAGS word with every other bit zero
	function automatic logic [31:0] pack_flags(input status_flags_t f);
		logic [31:0] e;
		e            = '0;
		e[EFLAGS_CF] = f.cf;
		e[EFLAGS_PF] = f.pf;
		e[EFLAGS_AF] = f.af;
		e[EFLAGS_ZF] = f.zf;
		e[EFLAGS_SF] = f.sf;
		e[EFLAGS_DF] = f.df;
		e[EFLAGS_OF] = f.of;
		return e;
	endfunction

	// Fixed-seed LCG with the high half folded into the low bits
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state ^ (lcg_state >> 16);
	endfunction

	// Reference model of result and flags
	function automatic void model_op(input alu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input status_flags_t cur,
		output logic [DATA_W-1:0] res, output status_flags_t nf);
		logic [DATA_W-1:0] bb;
		logic [63:0] wide;
		logic [7:0] al;
		logic cin, lo, hi;
		nf  = cur;
		res = a;
		bb  = (op == INC || op == DEC) ? DATA_W'(1) : b;
		cin = (op == ADC || op == SBB) ? cur.cf : 1'b0;
		case (op)
			ADD, ADC, INC: begin
				wide  = 64'(a) + 64'(bb) + 64'(cin);
				res   = wide[DATA_W-1:0];
				nf.cf = (op == INC) ? cur.cf : ((wide >> DATA_W) != 0);
				nf.af = (5'(a[3:0]) + 5'(bb[3:0]) + 5'(cin)) > 5'd15;
				nf.of = (a[DATA_W-1] == bb[DATA_W-1]) && (res[DATA_W-1] != a[DATA_W-1]);
			end
			SUB, SBB, CMP, DEC: begin
				res   = a - bb - DATA_W'(cin);
				nf.cf = (op == DEC) ? cur.cf : (64'(a) < 64'(bb) + 64'(cin));
				nf.af = 5'(a[3:0]) < 5'(bb[3:0]) + 5'(cin);
				nf.of = (a[DATA_W-1] != bb[DATA_W-1]) && (res[DATA_W-1] != a[DATA_W-1]);
			end
			AND, OR, XOR: begin
				res = (op == AND) ? (a & b) : (op == OR) ? (a | b) : (a ^ b);
				nf.cf = 1'b0;
				nf.of = 1'b0;
				nf.af = 1'b0;
			end
			DAA: begin
				al = a[7:0];
				// Digit rule on the old byte
				lo = (al[3:0] > 4'd9) || cur.af;
				hi = (al[7:4] > 4'd9) || (al[7:4] == 4'd9 && al[3:0] > 4'd9) || cur.cf;
				al = al + {(hi ? 4'h6 : 4'h0), (lo ? 4'h6 : 4'h0)};
				res   = {a[DATA_W-1:8], al};
				nf.af = lo;
				nf.cf = hi;
			end
			STC: nf.cf = 1'b1;
			CLC: nf.cf = 1'b0;
			CMC: nf.cf = ~cur.cf;
			STD: nf.df = 1'b1;
			CLD: nf.df = 1'b0;
			default: nf = cur;
		endcase
		if (!(op inside {STC, CLC, CMC, STD, CLD})) begin
			nf.sf = res[DATA_W-1];
			nf.zf = (op == DAA) ? (res[7:0] == 8'h00) : (res == '0);
			nf.pf = ~^res[7:0];
		end
	endfunction

	// Drive one strobe on the next edge and queue its expected outcome
	task automatic issue_op(input alu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		expect_t item;
		@(posedge clk);
		op_valid <= 1'b1;
		req.op   <= op;
		req.a    <= 32'(a);
		req.b    <= 32'(b);
		model_op(op, a, b, model_flags, item.res, item.flags);
		model_flags = item.flags;
		last_res    = item.res;
		item.we     = !(op inside {CMP, STC, CLC, CMC, STD, CLD});
		exp_q.push_back(item);
	endtask

	// Drop the strobe and wait until every queued result was checked
	task automatic end_burst();
		@(posedge clk);
		op_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	// Result checker sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && result_valid) begin
			if (exp_q.size() == 0)
				abort_run("result_valid went high with no operation outstanding");
			got_item = exp_q.pop_front();
			check_bit("result_we", result_we, got_item.we);
			if (got_item.we)
				check_result("result", result, got_item.res);
			check_flags(unpack_flags(eflags), got_item.flags);
			check_eflags(eflags, pack_flags(got_item.flags));
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run("Timeout: the tests did not finish within the cycle limit");
	end

	//----------------------------------------------------------------------
	// Directed tests
	//----------------------------------------------------------------------
	task automatic reset_and_valid();
		@(negedge clk);
		check_bit("result_valid", result_valid, 1'b0);
		check_bit("result_we", result_we, 1'b0);
		check_result("result", result, '0);
		check_flags(unpack_flags(eflags), '0);
		check_eflags(eflags, 32'd0);
		issue_op(ADD, 32'd5, 32'd7);
		@(posedge clk);
		op_valid <= 1'b0;
		@(negedge clk);
		check_bit("result_valid", result_valid, 1'b1);
		@(negedge clk);
		check_bit("result_valid", result_valid, 1'b0);
	endtask

	task automatic add_sub_boundaries();
		logic [DATA_W-1:0] bnd [4];
		logic [DATA_W-1:0] x, y;
		bnd = '{32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0};
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				issue_op(ADD, bnd[i], bnd[j]);
				issue_op(SUB, bnd[i], bnd[j]);
			end
		end
		for (int k = 0; k < 64; k++) begin
			x = lcg_next();
			y = lcg_next();
			issue_op(ADD, x, y);
			issue_op(SUB, x, y);
		end
		end_burst();
	endtask

	// 96-bit add and subtract with the carry passed across strobes
	task automatic carry_chains();
		issue_op(ADD, 32'hFFFF_FFFF, 32'h1);
		issue_op(ADC, 32'hFFFF_FFFF, 32'h0);
		issue_op(ADC, 32'h1, 32'h0);
		issue_op(SUB, 32'h0, 32'h1);
		issue_op(SBB, 32'h0, 32'h0);
		issue_op(SBB, 32'h5, 32'h2);
		issue_op(CMP, 32'h1234, 32'h1234);
		issue_op(CMP, 32'h1, 32'h2);
		end_burst();
	endtask

	task automatic logic_and_incdec();
		issue_op(ADD, 32'hFFFF_FFFF, 32'h1);
		issue_op(AND, lcg_next(), lcg_next());
		issue_op(ADD, 32'h7FFF_FFFF, 32'h1);
		issue_op(OR, lcg_next(), 32'h0);
		issue_op(ADD, 32'h0000_000F, 32'h1);
		issue_op(XOR, 32'hA5A5_A5A5, 32'hA5A5_A5A5);
		// Carry and borrow out while CF is clear
		issue_op(INC, 32'hFFFF_FFFF, 32'h0);
		issue_op(DEC, 32'h0, 32'h0);
		// No carry or borrow while CF is set
		issue_op(STC, 32'h0, 32'h0);
		issue_op(INC, 32'h7FFF_FFFF, 32'h0);
		issue_op(DEC, 32'h8000_0000, 32'h0);
		end_burst();
	endtask

	// Packed BCD add followed by the decimal adjust
	task automatic daa_sequences();
		logic [DATA_W-1:0] pairs [10];
		pairs = '{32'h19, 32'h28, 32'h99, 32'h01, 32'h55, 32'h55, 32'h38, 32'h45, 32'h199, 32'h1};
		for (int i = 0; i < 10; i += 2) begin
			issue_op(ADD, pairs[i], pairs[i+1]);
			issue_op(DAA, last_res, 32'h0);
		end
		end_burst();
	endtask

	task automatic flag_control_ops();
		issue_op(ADD, 32'h8000_0000, 32'h8000_0000);
		issue_op(CLC, lcg_next(), lcg_next());
		issue_op(CMC, lcg_next(), lcg_next());
		issue_op(CMC, lcg_next(), lcg_next());
		issue_op(STD, lcg_next(), lcg_next());
		issue_op(CLC, lcg_next(), lcg_next());
		issue_op(CLD, lcg_next(), lcg_next());
		issue_op(STC, lcg_next(), lcg_next());
		end_burst();
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		op_valid    = 1'b0;
		req         = '0;
		cycle_cnt   = 0;
		lcg_state   = 32'd13798;
		model_flags = '0;
		last_res    = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		reset_and_valid();
		add_sub_boundaries();
		carry_chains();
		logic_and_incdec();
		daa_sequences();
		flag_control_ops();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/alu_pkg.sv
source/alu_core.sv
source/flag_logic.sv
source/eflags_reg.sv
source/alu_flags_top.sv
test/alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ALU flag path testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -Mdir build -f filelist.f

# The simulator exits nonzero on failure, the log decides the outcome
./build/Valu_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
